// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := id_stage_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
RUN_ARGS  := +verilator+error+limit+100
PASS_MSG  := Testbench passed
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$($(SIM) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
design/mips_id_pkg.sv
design/id_decoder.sv
design/operand_fwd.sv
design/branch_unit.sv
design/id_ex_reg.sv
design/id_stage_top.sv
dv/id_stage_properties.sv
dv/id_stage_tb.sv

// ==== design/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
	input  wire mips_id_pkg::dec_ctrl_t   ctrl_i,
	input  wire [mips_id_pkg::DATA_W-1:0] inst_i,
	input  wire [mips_id_pkg::DATA_W-1:0] pc_i,
	input  wire [mips_id_pkg::DATA_W-1:0] reg1_i,
	input  wire [mips_id_pkg::DATA_W-1:0] reg2_i,
	input  wire                           stall_i,
	output mips_id_pkg::branch_t          branch_o
);

	logic [mips_id_pkg::DATA_W-1:0] pc_plus_4;
	logic [mips_id_pkg::DATA_W-1:0] pc_plus_8;
	logic [mips_id_pkg::DATA_W-1:0] br_target;
	logic [mips_id_pkg::DATA_W-1:0] jmp_target;
	logic [mips_id_pkg::DATA_W-1:0] target;
	logic cond;
	logic links;

	assign pc_plus_4 = pc_i + 32'd4;
	assign pc_plus_8 = pc_i + 32'd8;
	assign br_target = pc_plus_4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
	assign jmp_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};  // 256MB region

	assign links = ctrl_i.aluop inside {mips_id_pkg::ALU_JAL, mips_id_pkg::ALU_JALR,
		mips_id_pkg::ALU_BGEZAL, mips_id_pkg::ALU_BLTZAL};

	always_comb begin
		cond = 1'b0;
		target = br_target;
		case (ctrl_i.aluop)
			mips_id_pkg::ALU_BEQ:  cond = (reg1_i == reg2_i);
			mips_id_pkg::ALU_BNE:  cond = (reg1_i != reg2_i);
			mips_id_pkg::ALU_BGTZ: cond = !reg1_i[31] && (reg1_i != '0);
			mips_id_pkg::ALU_BLEZ: cond = reg1_i[31] || (reg1_i == '0);
			mips_id_pkg::ALU_BGEZ, mips_id_pkg::ALU_BGEZAL: cond = !reg1_i[31];
			mips_id_pkg::ALU_BLTZ, mips_id_pkg::ALU_BLTZAL: cond = reg1_i[31];
			mips_id_pkg::ALU_J, mips_id_pkg::ALU_JAL: begin
				cond = 1'b1;
				target = jmp_target;
			end
			mips_id_pkg::ALU_JR, mips_id_pkg::ALU_JALR: begin
				cond = 1'b1;
				target = reg1_i;
			end
			default: cond = 1'b0;
		endcase
	end

	assign branch_o.taken = cond && !stall_i;  // operand not ready yet
	assign branch_o.target = branch_o.taken ? target : '0;
	assign branch_o.link_addr = links ? pc_plus_8 : '0;  // skip the delay slot
	assign branch_o.next_in_delayslot = branch_o.taken;

endmodule

`default_nettype wire

// ==== design/id_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
	input  wire [mips_id_pkg::DATA_W-1:0] inst_i,
	output mips_id_pkg::dec_ctrl_t        ctrl_o
);

	logic [mips_id_pkg::REG_ADDR_W-1:0] rs;
	logic [mips_id_pkg::REG_ADDR_W-1:0] rt;
	logic [mips_id_pkg::REG_ADDR_W-1:0] rd;
	logic [4:0] shamt;
	logic [15:0] imm16;
	mips_id_pkg::op_e op;
	mips_id_pkg::funct_e funct;
	mips_id_pkg::regimm_e ri;
	logic valid;

	assign rs = inst_i[25:21];
	assign rt = inst_i[20:16];
	assign rd = inst_i[15:11];
	assign shamt = inst_i[10:6];
	assign imm16 = inst_i[15:0];
	assign op = mips_id_pkg::op_e'(inst_i[31:26]);
	assign funct = mips_id_pkg::funct_e'(inst_i[5:0]);
	assign ri = mips_id_pkg::regimm_e'(rt);

	always_comb begin
		ctrl_o.aluop = mips_id_pkg::ALU_NOP;
		ctrl_o.alusel = mips_id_pkg::SEL_NOP;
		ctrl_o.wd = rd;
		ctrl_o.wreg = 1'b0;
		ctrl_o.reg1_read = 1'b0;
		ctrl_o.reg2_read = 1'b0;
		ctrl_o.reg1_addr = rs;
		ctrl_o.reg2_addr = rt;
		ctrl_o.imm = '0;
		valid = 1'b1;

		case (op)
			mips_id_pkg::OP_SPECIAL: begin
				ctrl_o.wreg = 1'b1;
				ctrl_o.reg1_read = 1'b1;
				ctrl_o.reg2_read = 1'b1;
				case (funct)
					mips_id_pkg::FN_AND:  ctrl_o.aluop = mips_id_pkg::ALU_AND;
					mips_id_pkg::FN_OR:   ctrl_o.aluop = mips_id_pkg::ALU_OR;
					mips_id_pkg::FN_XOR:  ctrl_o.aluop = mips_id_pkg::ALU_XOR;
					mips_id_pkg::FN_NOR:  ctrl_o.aluop = mips_id_pkg::ALU_NOR;
					mips_id_pkg::FN_SLL, mips_id_pkg::FN_SLLV: ctrl_o.aluop = mips_id_pkg::ALU_SLL;
					mips_id_pkg::FN_SRL, mips_id_pkg::FN_SRLV: ctrl_o.aluop = mips_id_pkg::ALU_SRL;
					mips_id_pkg::FN_SRA, mips_id_pkg::FN_SRAV: ctrl_o.aluop = mips_id_pkg::ALU_SRA;
					mips_id_pkg::FN_ADD:  ctrl_o.aluop = mips_id_pkg::ALU_ADD;
					mips_id_pkg::FN_ADDU: ctrl_o.aluop = mips_id_pkg::ALU_ADDU;
					mips_id_pkg::FN_SUB:  ctrl_o.aluop = mips_id_pkg::ALU_SUB;
					mips_id_pkg::FN_SUBU: ctrl_o.aluop = mips_id_pkg::ALU_SUBU;
					mips_id_pkg::FN_SLT:  ctrl_o.aluop = mips_id_pkg::ALU_SLT;
					mips_id_pkg::FN_SLTU: ctrl_o.aluop = mips_id_pkg::ALU_SLTU;
					mips_id_pkg::FN_JR: begin
						ctrl_o.aluop = mips_id_pkg::ALU_JR;
						ctrl_o.wreg = 1'b0;
						ctrl_o.reg2_read = 1'b0;
					end
					mips_id_pkg::FN_JALR: begin
						ctrl_o.aluop = mips_id_pkg::ALU_JALR;  // link goes to rd
						ctrl_o.reg2_read = 1'b0;
					end
					default: valid = 1'b0;
				endcase
				if (funct inside {mips_id_pkg::FN_SLL, mips_id_pkg::FN_SRL, mips_id_pkg::FN_SRA}) begin
					ctrl_o.reg1_read = 1'b0;  // shamt rides in as operand 1
					ctrl_o.imm = {27'd0, shamt};
					if (rs != '0)
						valid = 1'b0;
				end else if (shamt != '0) begin
					valid = 1'b0;
				end
			end
			mips_id_pkg::OP_REGIMM: begin
				ctrl_o.reg1_read = 1'b1;
				case (ri)
					mips_id_pkg::RI_BLTZ:   ctrl_o.aluop = mips_id_pkg::ALU_BLTZ;
					mips_id_pkg::RI_BGEZ:   ctrl_o.aluop = mips_id_pkg::ALU_BGEZ;
					mips_id_pkg::RI_BLTZAL: ctrl_o.aluop = mips_id_pkg::ALU_BLTZAL;
					mips_id_pkg::RI_BGEZAL: ctrl_o.aluop = mips_id_pkg::ALU_BGEZAL;
					default: valid = 1'b0;
				endcase
			end
			mips_id_pkg::OP_J:   ctrl_o.aluop = mips_id_pkg::ALU_J;
			mips_id_pkg::OP_JAL: ctrl_o.aluop = mips_id_pkg::ALU_JAL;
			mips_id_pkg::OP_BEQ, mips_id_pkg::OP_BNE: begin
				ctrl_o.aluop = (op == mips_id_pkg::OP_BEQ) ? mips_id_pkg::ALU_BEQ
					: mips_id_pkg::ALU_BNE;
				ctrl_o.reg1_read = 1'b1;
				ctrl_o.reg2_read = 1'b1;
			end
			mips_id_pkg::OP_BLEZ, mips_id_pkg::OP_BGTZ: begin
				ctrl_o.aluop = (op == mips_id_pkg::OP_BLEZ) ? mips_id_pkg::ALU_BLEZ
					: mips_id_pkg::ALU_BGTZ;
				ctrl_o.reg1_read = 1'b1;
			end
			mips_id_pkg::OP_ANDI: begin
				ctrl_o.aluop = mips_id_pkg::ALU_AND;
				ctrl_o.imm = {16'd0, imm16};
			end
			mips_id_pkg::OP_ORI: begin
				ctrl_o.aluop = mips_id_pkg::ALU_OR;
				ctrl_o.imm = {16'd0, imm16};
			end
			mips_id_pkg::OP_XORI: begin
				ctrl_o.aluop = mips_id_pkg::ALU_XOR;
				ctrl_o.imm = {16'd0, imm16};
			end
			mips_id_pkg::OP_LUI: begin
				ctrl_o.aluop = mips_id_pkg::ALU_OR;  // rs is $0 in lui
				ctrl_o.imm = {imm16, 16'd0};
			end
			mips_id_pkg::OP_ADDI:  ctrl_o.aluop = mips_id_pkg::ALU_ADDI;
			mips_id_pkg::OP_ADDIU: ctrl_o.aluop = mips_id_pkg::ALU_ADDIU;
			mips_id_pkg::OP_SLTI:  ctrl_o.aluop = mips_id_pkg::ALU_SLT;
			mips_id_pkg::OP_SLTIU: ctrl_o.aluop = mips_id_pkg::ALU_SLTU;
			mips_id_pkg::OP_LB:    ctrl_o.aluop = mips_id_pkg::ALU_LB;
			mips_id_pkg::OP_LBU:   ctrl_o.aluop = mips_id_pkg::ALU_LBU;
			mips_id_pkg::OP_LW:    ctrl_o.aluop = mips_id_pkg::ALU_LW;
			mips_id_pkg::OP_SB, mips_id_pkg::OP_SW: begin
				ctrl_o.aluop = (op == mips_id_pkg::OP_SB) ? mips_id_pkg::ALU_SB
					: mips_id_pkg::ALU_SW;
				ctrl_o.reg1_read = 1'b1;  // base
				ctrl_o.reg2_read = 1'b1;  // store data
			end
			default: valid = 1'b0;
		endcase

		if (op inside {mips_id_pkg::OP_ADDI, mips_id_pkg::OP_ADDIU, mips_id_pkg::OP_SLTI,
				mips_id_pkg::OP_SLTIU})
			ctrl_o.imm = {{16{imm16[15]}}, imm16};

		// register-immediate forms write rt
		if (op inside {mips_id_pkg::OP_ANDI, mips_id_pkg::OP_ORI, mips_id_pkg::OP_XORI,
				mips_id_pkg::OP_LUI, mips_id_pkg::OP_ADDI, mips_id_pkg::OP_ADDIU,
				mips_id_pkg::OP_SLTI, mips_id_pkg::OP_SLTIU, mips_id_pkg::OP_LB,
				mips_id_pkg::OP_LBU, mips_id_pkg::OP_LW}) begin
			ctrl_o.wd = rt;
			ctrl_o.wreg = 1'b1;
			ctrl_o.reg1_read = 1'b1;
		end

		if (ctrl_o.aluop inside {mips_id_pkg::ALU_JAL, mips_id_pkg::ALU_BGEZAL,
				mips_id_pkg::ALU_BLTZAL}) begin
			ctrl_o.wd = mips_id_pkg::LINK_REG;
			ctrl_o.wreg = 1'b1;
		end

		if (!valid) begin
			ctrl_o.aluop = mips_id_pkg::ALU_NOP;
			ctrl_o.wreg = 1'b0;
			ctrl_o.reg1_read = 1'b0;
			ctrl_o.reg2_read = 1'b0;
		end

		case (ctrl_o.aluop)
			mips_id_pkg::ALU_NOP: ctrl_o.alusel = mips_id_pkg::SEL_NOP;
			mips_id_pkg::ALU_AND, mips_id_pkg::ALU_OR, mips_id_pkg::ALU_XOR,
			mips_id_pkg::ALU_NOR: ctrl_o.alusel = mips_id_pkg::SEL_LOGIC;
			mips_id_pkg::ALU_SLL, mips_id_pkg::ALU_SRL,
			mips_id_pkg::ALU_SRA: ctrl_o.alusel = mips_id_pkg::SEL_SHIFT;
			mips_id_pkg::ALU_ADD, mips_id_pkg::ALU_ADDU, mips_id_pkg::ALU_SUB,
			mips_id_pkg::ALU_SUBU, mips_id_pkg::ALU_SLT, mips_id_pkg::ALU_SLTU,
			mips_id_pkg::ALU_ADDI,
			mips_id_pkg::ALU_ADDIU: ctrl_o.alusel = mips_id_pkg::SEL_ARITHMETIC;
			mips_id_pkg::ALU_LB, mips_id_pkg::ALU_LBU, mips_id_pkg::ALU_LW,
			mips_id_pkg::ALU_SB,
			mips_id_pkg::ALU_SW: ctrl_o.alusel = mips_id_pkg::SEL_LOAD_STORE;
			default: ctrl_o.alusel = mips_id_pkg::SEL_JUMP_BRANCH;  // jumps and branches
		endcase
	end

endmodule

`default_nettype wire

// ==== design/id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
	input  wire                           clk,
	input  wire                           rst_n_i,
	input  wire                           stall_i,
	input  wire mips_id_pkg::dec_ctrl_t   ctrl_i,
	input  wire [mips_id_pkg::DATA_W-1:0] reg1_i,
	input  wire [mips_id_pkg::DATA_W-1:0] reg2_i,
	input  wire [mips_id_pkg::DATA_W-1:0] link_addr_i,
	input  wire                           is_in_delayslot_i,
	input  wire [mips_id_pkg::DATA_W-1:0] inst_i,
	output mips_id_pkg::id_ex_t           id_ex_o
);

	mips_id_pkg::id_ex_t nxt;

	always_comb begin
		nxt.aluop = ctrl_i.aluop;
		nxt.alusel = ctrl_i.alusel;
		nxt.reg1 = reg1_i;
		nxt.reg2 = reg2_i;
		nxt.wd = ctrl_i.wd;
		nxt.wreg = ctrl_i.wreg;
		nxt.link_addr = link_addr_i;
		nxt.is_in_delayslot = is_in_delayslot_i;
		nxt.inst = inst_i;
		if (stall_i) begin  // bubble into execute
			nxt.aluop = mips_id_pkg::ALU_NOP;
			nxt.alusel = mips_id_pkg::SEL_NOP;
			nxt.wreg = 1'b0;
			nxt.reg1 = '0;
			nxt.reg2 = '0;
			nxt.is_in_delayslot = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			id_ex_o <= '0;  // NOP opcode and class are both zero
		else
			id_ex_o <= nxt;
	end

endmodule

`default_nettype wire

// ==== design/id_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage_top (
	input  wire                                  clk,
	input  wire                                  rst_n_i,
	input  wire [mips_id_pkg::DATA_W-1:0]        pc_i,
	input  wire [mips_id_pkg::DATA_W-1:0]        inst_i,
	input  wire [mips_id_pkg::DATA_W-1:0]        reg1_data_i,
	input  wire [mips_id_pkg::DATA_W-1:0]        reg2_data_i,
	input  wire mips_id_pkg::fwd_t               ex_fwd_i,
	input  wire mips_id_pkg::fwd_t               mem_fwd_i,
	input  wire mips_id_pkg::alu_op_e            ex_aluop_i,
	input  wire                                  is_in_delayslot_i,
	output logic                                 reg1_read_o,
	output logic                                 reg2_read_o,
	output logic [mips_id_pkg::REG_ADDR_W-1:0]   reg1_addr_o,
	output logic [mips_id_pkg::REG_ADDR_W-1:0]   reg2_addr_o,
	output mips_id_pkg::branch_t                 branch_o,
	output logic                                 stall_o,
	output mips_id_pkg::id_ex_t                  id_ex_o
);

	mips_id_pkg::dec_ctrl_t ctrl;
	logic [mips_id_pkg::DATA_W-1:0] reg1;
	logic [mips_id_pkg::DATA_W-1:0] reg2;

	id_decoder u_decoder (
		.inst_i (inst_i),
		.ctrl_o (ctrl)
	);

	// register file read port requests
	assign reg1_read_o = ctrl.reg1_read;
	assign reg2_read_o = ctrl.reg2_read;
	assign reg1_addr_o = ctrl.reg1_addr;
	assign reg2_addr_o = ctrl.reg2_addr;

	operand_fwd u_fwd (
		.ctrl_i      (ctrl),
		.reg1_data_i (reg1_data_i),
		.reg2_data_i (reg2_data_i),
		.ex_fwd_i    (ex_fwd_i),
		.mem_fwd_i   (mem_fwd_i),
		.ex_aluop_i  (ex_aluop_i),
		.reg1_o      (reg1),
		.reg2_o      (reg2),
		.stall_o     (stall_o)
	);

	branch_unit u_branch (
		.ctrl_i   (ctrl),
		.inst_i   (inst_i),
		.pc_i     (pc_i),
		.reg1_i   (reg1),
		.reg2_i   (reg2),
		.stall_i  (stall_o),
		.branch_o (branch_o)
	);

	id_ex_reg u_id_ex (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.stall_i           (stall_o),
		.ctrl_i            (ctrl),
		.reg1_i            (reg1),
		.reg2_i            (reg2),
		.link_addr_i       (branch_o.link_addr),
		.is_in_delayslot_i (is_in_delayslot_i),
		.inst_i            (inst_i),
		.id_ex_o           (id_ex_o)
	);

endmodule

`default_nettype wire

// ==== design/mips_id_pkg.sv ====
`default_nettype none

package mips_id_pkg;

	localparam int DATA_W = 32;
	localparam int REG_ADDR_W = 5;
	localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;  // $ra

	// primary opcode field, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_REGIMM  = 6'b000001,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111,
		OP_LB      = 6'b100000,
		OP_LW      = 6'b100011,
		OP_LBU     = 6'b100100,
		OP_SB      = 6'b101000,
		OP_SW      = 6'b101011
	} op_e;

	// function field of SPECIAL, inst[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_JR   = 6'b001000,
		FN_JALR = 6'b001001,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// rt field of REGIMM
	typedef enum logic [4:0] {
		RI_BLTZ   = 5'b00000,
		RI_BGEZ   = 5'b00001,
		RI_BLTZAL = 5'b10000,
		RI_BGEZAL = 5'b10001
	} regimm_e;

	typedef enum logic [7:0] {
		ALU_NOP    = 8'h00,
		ALU_AND    = 8'h24,
		ALU_OR     = 8'h25,
		ALU_XOR    = 8'h26,
		ALU_NOR    = 8'h27,
		ALU_SLL    = 8'h7c,
		ALU_SRL    = 8'h02,
		ALU_SRA    = 8'h03,
		ALU_ADD    = 8'h20,
		ALU_ADDU   = 8'h21,
		ALU_SUB    = 8'h22,
		ALU_SUBU   = 8'h23,
		ALU_SLT    = 8'h2a,
		ALU_SLTU   = 8'h2b,
		ALU_ADDI   = 8'h55,
		ALU_ADDIU  = 8'h56,
		ALU_J      = 8'h4f,
		ALU_JAL    = 8'h50,
		ALU_JR     = 8'h08,
		ALU_JALR   = 8'h09,
		ALU_BEQ    = 8'h51,
		ALU_BNE    = 8'h52,
		ALU_BLEZ   = 8'h53,
		ALU_BGTZ   = 8'h54,
		ALU_BLTZ   = 8'h40,
		ALU_BGEZ   = 8'h41,
		ALU_BLTZAL = 8'h4a,
		ALU_BGEZAL = 8'h4b,
		ALU_LB     = 8'he0,
		ALU_LW     = 8'he3,
		ALU_LBU    = 8'he4,
		ALU_SB     = 8'he8,
		ALU_SW     = 8'heb
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITHMETIC  = 3'b100,
		SEL_JUMP_BRANCH = 3'b110,
		SEL_LOAD_STORE  = 3'b111
	} alu_sel_e;

	typedef struct packed {
		logic                  we;
		logic [REG_ADDR_W-1:0] waddr;
		logic [DATA_W-1:0]     wdata;
	} fwd_t;

	typedef struct packed {
		alu_op_e               aluop;
		alu_sel_e              alusel;
		logic [REG_ADDR_W-1:0] wd;
		logic                  wreg;
		logic                  reg1_read;
		logic                  reg2_read;
		logic [REG_ADDR_W-1:0] reg1_addr;
		logic [REG_ADDR_W-1:0] reg2_addr;
		logic [DATA_W-1:0]     imm;
	} dec_ctrl_t;

	typedef struct packed {
		logic              taken;
		logic [DATA_W-1:0] target;
		logic [DATA_W-1:0] link_addr;
		logic              next_in_delayslot;
	} branch_t;

	typedef struct packed {
		alu_op_e               aluop;
		alu_sel_e              alusel;
		logic [DATA_W-1:0]     reg1;
		logic [DATA_W-1:0]     reg2;
		logic [REG_ADDR_W-1:0] wd;
		logic                  wreg;
		logic [DATA_W-1:0]     link_addr;
		logic                  is_in_delayslot;
		logic [DATA_W-1:0]     inst;
	} id_ex_t;

	function automatic logic is_load_op(alu_op_e op);
		return op inside {ALU_LB, ALU_LBU, ALU_LW};
	endfunction

endpackage

`default_nettype wire

// ==== design/operand_fwd.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fwd (
	input  wire mips_id_pkg::dec_ctrl_t   ctrl_i,
	input  wire [mips_id_pkg::DATA_W-1:0] reg1_data_i,
	input  wire [mips_id_pkg::DATA_W-1:0] reg2_data_i,
	input  wire mips_id_pkg::fwd_t        ex_fwd_i,
	input  wire mips_id_pkg::fwd_t        mem_fwd_i,
	input  wire mips_id_pkg::alu_op_e     ex_aluop_i,
	output logic [mips_id_pkg::DATA_W-1:0] reg1_o,
	output logic [mips_id_pkg::DATA_W-1:0] reg2_o,
	output logic                          stall_o
);

	logic ex_is_load;
	logic [mips_id_pkg::DATA_W:0] src1;
	logic [mips_id_pkg::DATA_W:0] src2;

	// returns {load_use, operand}
	function automatic logic [mips_id_pkg::DATA_W:0] select_src(
		input logic                                 rd_en,
		input logic [mips_id_pkg::REG_ADDR_W-1:0]   addr,
		input logic [mips_id_pkg::DATA_W-1:0]       rf_data,
		input logic [mips_id_pkg::DATA_W-1:0]       imm,
		input mips_id_pkg::fwd_t                    ex,
		input mips_id_pkg::fwd_t                    mem,
		input logic                                 ex_load
	);
		if (!rd_en)
			return {1'b0, imm};
		if (ex_load && ex.waddr == addr)
			return {1'b1, {mips_id_pkg::DATA_W{1'b0}}};  // data still in memory
		if (ex.we && ex.waddr == addr)
			return {1'b0, ex.wdata};
		if (mem.we && mem.waddr == addr)
			return {1'b0, mem.wdata};
		return {1'b0, rf_data};
	endfunction

	assign ex_is_load = mips_id_pkg::is_load_op(ex_aluop_i);

	assign src1 = select_src(ctrl_i.reg1_read, ctrl_i.reg1_addr, reg1_data_i, ctrl_i.imm,
		ex_fwd_i, mem_fwd_i, ex_is_load);
	assign src2 = select_src(ctrl_i.reg2_read, ctrl_i.reg2_addr, reg2_data_i, ctrl_i.imm,
		ex_fwd_i, mem_fwd_i, ex_is_load);

	assign reg1_o = src1[mips_id_pkg::DATA_W-1:0];
	assign reg2_o = src2[mips_id_pkg::DATA_W-1:0];
	assign stall_o = src1[mips_id_pkg::DATA_W] | src2[mips_id_pkg::DATA_W];

endmodule

`default_nettype wire

// ==== dv/id_stage_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage_properties (
	input wire                                clk,
	input wire                                rst_n_i,
	input wire mips_id_pkg::alu_op_e          ex_aluop_i,
	input wire mips_id_pkg::fwd_t             ex_fwd_i,
	input wire                                reg1_read_i,
	input wire                                reg2_read_i,
	input wire [mips_id_pkg::REG_ADDR_W-1:0]  reg1_addr_i,
	input wire [mips_id_pkg::REG_ADDR_W-1:0]  reg2_addr_i,
	input wire                                stall_i,
	input wire mips_id_pkg::branch_t          branch_i,
	input wire mips_id_pkg::id_ex_t           id_ex_i
);

	logic ex_load;
	logic load_use;
	int fail_count = 0;

	assign ex_load = (ex_aluop_i == mips_id_pkg::ALU_LB) || (ex_aluop_i == mips_id_pkg::ALU_LBU)
		|| (ex_aluop_i == mips_id_pkg::ALU_LW);
	assign load_use = ex_load && ((reg1_read_i && reg1_addr_i == ex_fwd_i.waddr)
		|| (reg2_read_i && reg2_addr_i == ex_fwd_i.waddr));

	assert property (@(posedge clk) disable iff (!rst_n_i) load_use |-> stall_i)
		else begin
			$error("load-use hazard seen but no stall raised");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n_i) !load_use |-> !stall_i)
		else begin
			$error("stall raised without a load-use hazard");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n_i) stall_i |-> !branch_i.taken)
		else begin
			$error("branch taken while stalled");
			fail_count++;
		end

	// a stalled instruction must not reach execute
	assert property (@(posedge clk) disable iff (!rst_n_i)
		stall_i |=> (id_ex_i.aluop == mips_id_pkg::ALU_NOP
			&& id_ex_i.alusel == mips_id_pkg::SEL_NOP && !id_ex_i.wreg))
		else begin
			$error("no bubble in ID/EX after a stall");
			fail_count++;
		end

	assert property (@(posedge clk) !rst_n_i |-> (!id_ex_i.wreg
		&& id_ex_i.aluop == mips_id_pkg::ALU_NOP))
		else begin
			$error("ID/EX not a bubble during reset");
			fail_count++;
		end

endmodule

`default_nettype wire

// ==== dv/id_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb;

	localparam int N_RAND = 12;
	localparam int STIM_CYCLES = 32 + 8 * N_RAND;  // reset, directed, random branches
	localparam int MAX_CYCLES = 3 * STIM_CYCLES;

	logic clk;
	logic rst_n;
	logic [31:0] pc;
	logic [31:0] inst;
	logic [31:0] reg1_data;
	logic [31:0] reg2_data;
	mips_id_pkg::fwd_t ex_fwd;
	mips_id_pkg::fwd_t mem_fwd;
	mips_id_pkg::alu_op_e ex_aluop;
	logic in_ds;
	logic reg1_read;
	logic reg2_read;
	logic [4:0] reg1_addr;
	logic [4:0] reg2_addr;
	mips_id_pkg::branch_t branch;
	logic stall;
	mips_id_pkg::id_ex_t id_ex;

	mips_id_pkg::fwd_t ex_nx;  // applied at the next falling edge
	mips_id_pkg::fwd_t mem_nx;
	mips_id_pkg::alu_op_e exop_nx;

	logic [31:0] rf [32];
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	assign reg1_data = rf[reg1_addr];  // register file answers in the same cycle
	assign reg2_data = rf[reg2_addr];

	id_stage_top uut (
		.clk               (clk),
		.rst_n_i           (rst_n),
		.pc_i              (pc),
		.inst_i            (inst),
		.reg1_data_i       (reg1_data),
		.reg2_data_i       (reg2_data),
		.ex_fwd_i          (ex_fwd),
		.mem_fwd_i         (mem_fwd),
		.ex_aluop_i        (ex_aluop),
		.is_in_delayslot_i (in_ds),
		.reg1_read_o       (reg1_read),
		.reg2_read_o       (reg2_read),
		.reg1_addr_o       (reg1_addr),
		.reg2_addr_o       (reg2_addr),
		.branch_o          (branch),
		.stall_o           (stall),
		.id_ex_o           (id_ex)
	);

	bind id_stage_top id_stage_properties u_props (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.ex_aluop_i  (ex_aluop_i),
		.ex_fwd_i    (ex_fwd_i),
		.reg1_read_i (reg1_read_o),
		.reg2_read_i (reg2_read_o),
		.reg1_addr_i (reg1_addr_o),
		.reg2_addr_i (reg2_addr_o),
		.stall_i     (stall_o),
		.branch_i    (branch_o),
		.id_ex_i     (id_ex_o)
	);

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, errors: %0d of %0d checks, %0d property failures",
				cycles, errors, checks, uut.u_props.fail_count);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [4:0] sa, input mips_id_pkg::funct_e fn);
		return {6'b000000, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] i_type(input mips_id_pkg::op_e op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic drive(input logic [31:0] iw, input logic [31:0] pcw, input logic ds);
		@(negedge clk);
		ex_fwd = ex_nx;
		mem_fwd = mem_nx;
		ex_aluop = exop_nx;
		inst = iw;
		pc = pcw;
		in_ds = ds;
		#2;
	endtask

	task automatic check_latched(input string name, input mips_id_pkg::alu_op_e op,
			input mips_id_pkg::alu_sel_e sel, input logic [4:0] wd, input logic wreg,
			input logic ds);
		@(posedge clk);
		#2;
		expect_eq({name, " aluop"}, 32'(op), 32'(id_ex.aluop));
		expect_eq({name, " alusel"}, 32'(sel), 32'(id_ex.alusel));
		expect_eq({name, " wreg"}, 32'(wreg), 32'(id_ex.wreg));
		if (wreg)
			expect_eq({name, " wd"}, 32'(wd), 32'(id_ex.wd));
		expect_eq({name, " delay slot"}, 32'(ds), 32'(id_ex.is_in_delayslot));
	endtask

	task automatic run_alu(input string name, input logic [31:0] iw, input logic ds,
			input mips_id_pkg::alu_op_e op, input mips_id_pkg::alu_sel_e sel,
			input logic [4:0] wd, input logic [31:0] r1, input logic [31:0] r2);
		drive(iw, 32'h0040_0000, ds);
		expect_eq({name, " stall"}, 32'd0, 32'(stall));
		check_latched(name, op, sel, wd, 1'b1, ds);
		expect_eq({name, " reg1"}, r1, id_ex.reg1);
		expect_eq({name, " reg2"}, r2, id_ex.reg2);
		expect_eq({name, " inst"}, iw, id_ex.inst);
	endtask

	// operands sit in r1 and r2 of the register file
	task automatic run_branch(input string name, input logic [31:0] iw, input logic [31:0] pcw,
			input logic [31:0] a, input logic [31:0] b, input logic taken,
			input logic [31:0] target, input logic [31:0] link,
			input mips_id_pkg::alu_op_e op, input logic [4:0] wd, input logic wreg);
		@(negedge clk);
		rf[1] = a;
		rf[2] = b;
		ex_fwd = ex_nx;
		mem_fwd = mem_nx;
		ex_aluop = exop_nx;
		inst = iw;
		pc = pcw;
		in_ds = 1'b0;
		#2;
		expect_eq({name, " taken"}, 32'(taken), 32'(branch.taken));
		expect_eq({name, " delay slot mark"}, 32'(taken), 32'(branch.next_in_delayslot));
		if (taken)
			expect_eq({name, " target"}, target, branch.target);
		expect_eq({name, " link"}, link, branch.link_addr);
		check_latched(name, op, mips_id_pkg::SEL_JUMP_BRANCH, wd, wreg, 1'b0);
		expect_eq({name, " latched link"}, link, id_ex.link_addr);
		expect_eq({name, " inst"}, iw, id_ex.inst);
	endtask

	initial begin : stimulus
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] rnd;
		logic [31:0] pcw;
		logic [31:0] bt;
		logic [31:0] fx;
		logic [31:0] fm;
		logic [15:0] off;

		void'($urandom(32'h16a3));
		for (int i = 0; i < 32; i++)
			rf[i] = 32'hc000_0000 | (i * 32'h0001_0101);
		rf[0] = 32'd0;
		rst_n = 1'b0;
		pc = 32'd0;
		inst = 32'd0;
		in_ds = 1'b0;
		ex_nx = '0;
		mem_nx = '0;
		exop_nx = mips_id_pkg::ALU_NOP;
		ex_fwd = '0;
		mem_fwd = '0;
		ex_aluop = mips_id_pkg::ALU_NOP;

		repeat (3) @(posedge clk);
		#2;
		expect_eq("reset wreg", 32'd0, 32'(id_ex.wreg));
		expect_eq("reset aluop", 32'(mips_id_pkg::ALU_NOP), 32'(id_ex.aluop));
		@(negedge clk);
		rst_n = 1'b1;
		#2;
		expect_eq("after reset wreg", 32'd0, 32'(id_ex.wreg));
		expect_eq("after reset delay slot", 32'd0, 32'(id_ex.is_in_delayslot));

		run_alu("add", r_type(5'd1, 5'd2, 5'd3, 5'd0, mips_id_pkg::FN_ADD), 1'b1,
			mips_id_pkg::ALU_ADD, mips_id_pkg::SEL_ARITHMETIC, 5'd3, rf[1], rf[2]);
		expect_eq("add reg1 addr", 32'd1, 32'(reg1_addr));
		expect_eq("add reg2 addr", 32'd2, 32'(reg2_addr));
		expect_eq("add read flags", 32'd3, 32'({reg1_read, reg2_read}));

		run_alu("ori", i_type(mips_id_pkg::OP_ORI, 5'd4, 5'd5, 16'h8001), 1'b0,
			mips_id_pkg::ALU_OR, mips_id_pkg::SEL_LOGIC, 5'd5, rf[4], 32'h0000_8001);
		run_alu("andi", i_type(mips_id_pkg::OP_ANDI, 5'd4, 5'd6, 16'hf0f0), 1'b1,
			mips_id_pkg::ALU_AND, mips_id_pkg::SEL_LOGIC, 5'd6, rf[4], 32'h0000_f0f0);
		run_alu("addi", i_type(mips_id_pkg::OP_ADDI, 5'd4, 5'd7, 16'h8004), 1'b0,
			mips_id_pkg::ALU_ADDI, mips_id_pkg::SEL_ARITHMETIC, 5'd7, rf[4], 32'hffff_8004);
		run_alu("slti", i_type(mips_id_pkg::OP_SLTI, 5'd4, 5'd8, 16'hfffe), 1'b0,
			mips_id_pkg::ALU_SLT, mips_id_pkg::SEL_ARITHMETIC, 5'd8, rf[4], 32'hffff_fffe);
		run_alu("lui", i_type(mips_id_pkg::OP_LUI, 5'd0, 5'd9, 16'h1234), 1'b0,
			mips_id_pkg::ALU_OR, mips_id_pkg::SEL_LOGIC, 5'd9, 32'd0, 32'h1234_0000);
		run_alu("sll", r_type(5'd0, 5'd2, 5'd10, 5'd7, mips_id_pkg::FN_SLL), 1'b0,
			mips_id_pkg::ALU_SLL, mips_id_pkg::SEL_SHIFT, 5'd10, 32'd7, rf[2]);
		run_alu("sra", r_type(5'd0, 5'd3, 5'd11, 5'd31, mips_id_pkg::FN_SRA), 1'b0,
			mips_id_pkg::ALU_SRA, mips_id_pkg::SEL_SHIFT, 5'd11, 32'd31, rf[3]);
		run_alu("sllv", r_type(5'd5, 5'd2, 5'd12, 5'd0, mips_id_pkg::FN_SLLV), 1'b0,
			mips_id_pkg::ALU_SLL, mips_id_pkg::SEL_SHIFT, 5'd12, rf[5], rf[2]);

		// same index in execute, memory and register file
		fx = $urandom;
		fm = $urandom;
		exop_nx = mips_id_pkg::ALU_ADD;
		ex_nx = '{we: 1'b1, waddr: 5'd13, wdata: fx};
		mem_nx = '{we: 1'b1, waddr: 5'd13, wdata: fm};
		run_alu("fwd ex first", r_type(5'd13, 5'd14, 5'd12, 5'd0, mips_id_pkg::FN_ADD), 1'b0,
			mips_id_pkg::ALU_ADD, mips_id_pkg::SEL_ARITHMETIC, 5'd12, fx, rf[14]);
		ex_nx.we = 1'b0;
		run_alu("fwd mem", r_type(5'd13, 5'd14, 5'd12, 5'd0, mips_id_pkg::FN_ADD), 1'b0,
			mips_id_pkg::ALU_ADD, mips_id_pkg::SEL_ARITHMETIC, 5'd12, fm, rf[14]);
		mem_nx.we = 1'b0;
		run_alu("fwd regfile", r_type(5'd13, 5'd14, 5'd12, 5'd0, mips_id_pkg::FN_ADD), 1'b0,
			mips_id_pkg::ALU_ADD, mips_id_pkg::SEL_ARITHMETIC, 5'd12, rf[13], rf[14]);
		ex_nx = '{we: 1'b1, waddr: 5'd14, wdata: fx};
		mem_nx = '{we: 1'b1, waddr: 5'd13, wdata: fm};
		run_alu("fwd split", r_type(5'd13, 5'd14, 5'd12, 5'd0, mips_id_pkg::FN_ADD), 1'b0,
			mips_id_pkg::ALU_ADD, mips_id_pkg::SEL_ARITHMETIC, 5'd12, fm, fx);

		// load in execute feeding this instruction
		mem_nx = '0;
		exop_nx = mips_id_pkg::ALU_LW;
		ex_nx = '{we: 1'b1, waddr: 5'd13, wdata: fx};
		drive(i_type(mips_id_pkg::OP_BEQ, 5'd13, 5'd13, 16'h0010), 32'h0040_0100, 1'b0);
		expect_eq("load-use beq stall", 32'd1, 32'(stall));
		expect_eq("load-use beq taken", 32'd0, 32'(branch.taken));
		check_latched("load-use beq bubble", mips_id_pkg::ALU_NOP, mips_id_pkg::SEL_NOP,
			5'd0, 1'b0, 1'b0);
		drive(r_type(5'd1, 5'd13, 5'd3, 5'd0, mips_id_pkg::FN_ADD), 32'h0040_0104, 1'b0);
		expect_eq("load-use rt stall", 32'd1, 32'(stall));
		check_latched("load-use rt bubble", mips_id_pkg::ALU_NOP, mips_id_pkg::SEL_NOP,
			5'd0, 1'b0, 1'b0);
		ex_nx.waddr = 5'd20;
		run_alu("load no match", r_type(5'd1, 5'd2, 5'd3, 5'd0, mips_id_pkg::FN_ADD), 1'b0,
			mips_id_pkg::ALU_ADD, mips_id_pkg::SEL_ARITHMETIC, 5'd3, rf[1], rf[2]);
		ex_nx = '0;
		exop_nx = mips_id_pkg::ALU_NOP;

		for (int n = 0; n < N_RAND; n++) begin
			a = $urandom;
			b = $urandom;
			if (n % 4 == 1)
				b = a;
			if (n % 4 == 2)
				a = 32'd0;
			rnd = $urandom;
			off = rnd[15:0];
			rnd = $urandom;
			pcw = {rnd[31:2], 2'b00};
			bt = pcw + 32'd4 + {{14{off[15]}}, off, 2'b00};
			run_branch("beq", i_type(mips_id_pkg::OP_BEQ, 5'd1, 5'd2, off), pcw, a, b,
				a == b, bt, 32'd0, mips_id_pkg::ALU_BEQ, 5'd0, 1'b0);
			run_branch("bne", i_type(mips_id_pkg::OP_BNE, 5'd1, 5'd2, off), pcw, a, b,
				a != b, bt, 32'd0, mips_id_pkg::ALU_BNE, 5'd0, 1'b0);
			run_branch("bgtz", i_type(mips_id_pkg::OP_BGTZ, 5'd1, 5'd0, off), pcw, a, b,
				!a[31] && a != 32'd0, bt, 32'd0, mips_id_pkg::ALU_BGTZ, 5'd0, 1'b0);
			run_branch("blez", i_type(mips_id_pkg::OP_BLEZ, 5'd1, 5'd0, off), pcw, a, b,
				a[31] || a == 32'd0, bt, 32'd0, mips_id_pkg::ALU_BLEZ, 5'd0, 1'b0);
			run_branch("bgez", i_type(mips_id_pkg::OP_REGIMM, 5'd1, mips_id_pkg::RI_BGEZ, off),
				pcw, a, b, !a[31], bt, 32'd0, mips_id_pkg::ALU_BGEZ, 5'd0, 1'b0);
			run_branch("bltz", i_type(mips_id_pkg::OP_REGIMM, 5'd1, mips_id_pkg::RI_BLTZ, off),
				pcw, a, b, a[31], bt, 32'd0, mips_id_pkg::ALU_BLTZ, 5'd0, 1'b0);
			run_branch("bgezal", i_type(mips_id_pkg::OP_REGIMM, 5'd1, mips_id_pkg::RI_BGEZAL, off),
				pcw, a, b, !a[31], bt, pcw + 32'd8, mips_id_pkg::ALU_BGEZAL, 5'd31, 1'b1);
			run_branch("bltzal", i_type(mips_id_pkg::OP_REGIMM, 5'd1, mips_id_pkg::RI_BLTZAL, off),
				pcw, a, b, a[31], bt, pcw + 32'd8, mips_id_pkg::ALU_BLTZAL, 5'd31, 1'b1);
		end

		rnd = $urandom;
		pcw = {rnd[31:2], 2'b00};
		a = {rnd[29:0], 2'b00};
		rnd = $urandom;
		bt = {pcw[31:28] + {3'b000, &pcw[27:2]}, rnd[25:0], 2'b00};  // region of pc+4
		run_branch("j", {mips_id_pkg::OP_J, rnd[25:0]}, pcw, a, 32'd0, 1'b1, bt, 32'd0,
			mips_id_pkg::ALU_J, 5'd0, 1'b0);
		run_branch("jal", {mips_id_pkg::OP_JAL, rnd[25:0]}, pcw, a, 32'd0, 1'b1, bt,
			pcw + 32'd8, mips_id_pkg::ALU_JAL, 5'd31, 1'b1);
		run_branch("jr", r_type(5'd1, 5'd0, 5'd0, 5'd0, mips_id_pkg::FN_JR), pcw, a, 32'd0,
			1'b1, a, 32'd0, mips_id_pkg::ALU_JR, 5'd0, 1'b0);
		run_branch("jalr", r_type(5'd1, 5'd0, 5'd17, 5'd0, mips_id_pkg::FN_JALR), pcw, a, 32'd0,
			1'b1, a, pcw + 32'd8, mips_id_pkg::ALU_JALR, 5'd17, 1'b1);

		@(negedge clk);
		$display("checks: %0d, errors: %0d, property failures: %0d", checks, errors,
			uut.u_props.fail_count);
		if (errors == 0 && uut.u_props.fail_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
